/* hdl/icebreaker_pkg.sv */
//**********************************************************
// Shared definitions for the iCEBreaker debug subsystem
// Data byte and JTAG instruction typedefs, instruction codes
// IDCODE word, mailbox DR width, TAP state enum
// Mailbox command and status structs
//**********************************************************

package icebreaker_pkg;

	typedef logic [7:0] byte_t; // UART payload
	typedef logic [3:0] ir_t;   // JTAG instruction

	// Instruction codes, anything unlisted behaves as BYPASS
	localparam ir_t IR_IDCODE  = 4'h1;
	localparam ir_t IR_MAILBOX = 4'h2;
	localparam ir_t IR_BYPASS  = 4'hf;

	localparam logic [31:0] IDCODE_VALUE = 32'h1c3b_0a4d; // Bit 0 set as JTAG requires

	localparam int MBOX_DR_W = 11; // tx_go, rx_pop, clr_ovf, data

	// Standard IEEE 1149.1 controller states
	typedef enum logic [3:0] {
		TEST_LOGIC_RESET,
		RUN_TEST_IDLE,
		SELECT_DR,
		CAPTURE_DR,
		SHIFT_DR,
		EXIT1_DR,
		PAUSE_DR,
		EXIT2_DR,
		UPDATE_DR,
		SELECT_IR,
		CAPTURE_IR,
		SHIFT_IR,
		EXIT1_IR,
		PAUSE_IR,
		EXIT2_IR,
		UPDATE_IR
	} tap_state_t;

	// Command from the TAP, upper bits mirror the DR layout
	typedef struct packed {
		logic  tx_go;   // Send data over UART
		logic  rx_pop;  // Drop FIFO head
		logic  clr_ovf; // Clear sticky overflow
		byte_t data;
		logic  valid;   // Qualifies the whole word
	} mbox_cmd_t;

	// Status word captured at Capture-DR under MAILBOX
	typedef struct packed {
		logic  overflow;
		logic  tx_busy;
		logic  rx_valid; // FIFO not empty
		byte_t rx_data;  // FIFO head
	} mbox_stat_t;

endpackage

/* hdl/fpga_reset.sv */
//**********************************************************
// Reset stretcher
// Power-on and button reset folded into one synchronous
// system reset of fixed length
//**********************************************************

module fpga_reset #(
	parameter int RST_SHIFT = 3 // Stretch length in cycles
) (
	input  logic clk,
	input  logic rst,
	output logic rst_out
);

	// All ones at configuration, so the system starts in reset
	logic [RST_SHIFT-1:0] stretch = '1;

	always_ff @(posedge clk) begin
		if (rst) begin
			stretch <= '1; // Refill while the button is held
		end else begin
			stretch <= stretch << 1; // Zeros walk toward the top stage
		end
	end

	// Top stage drops RST_SHIFT cycles after rst goes away
	assign rst_out = stretch[RST_SHIFT-1];

endmodule

/* hdl/jtag_tap.sv */
//**********************************************************
// JTAG TAP controller, oversampled in the system clock
// Pin synchronisers and tck edge detection
// 16-state controller, 4-bit IR, shared 32-bit DR
// IDCODE, BYPASS and mailbox data registers
//**********************************************************

module jtag_tap (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     tck,
	input  logic                     tms,
	input  logic                     tdi,
	output logic                     tdo,
	input  icebreaker_pkg::mbox_stat_t stat,
	output icebreaker_pkg::mbox_cmd_t  cmd
);

	logic [2:0] pins_meta; // {tck, tms, tdi}
	logic [2:0] pins_sync;
	logic       tck_prev;
	logic       tck_rise;
	logic       tck_fall;
	logic       tms_s;
	logic       tdi_s;

	icebreaker_pkg::tap_state_t state;
	icebreaker_pkg::tap_state_t state_next;
	icebreaker_pkg::ir_t        ir;
	icebreaker_pkg::ir_t        ir_sh; // IR shift stage
	logic [31:0]                dr;    // One register for every DR
	logic [31:0]                dr_shifted;

	// Two flops on all pins keep tms and tdi aligned with tck
	always_ff @(posedge clk) begin
		if (rst) begin
			pins_meta <= '0;
			pins_sync <= '0;
			tck_prev  <= 1'b0;
		end else begin
			pins_meta <= {tck, tms, tdi};
			pins_sync <= pins_meta;
			tck_prev  <= pins_sync[2];
		end
	end

	assign tms_s    = pins_sync[1];
	assign tdi_s    = pins_sync[0];
	assign tck_rise = pins_sync[2] & ~tck_prev;
	assign tck_fall = ~pins_sync[2] & tck_prev;

	// Controller transitions, sampled tms
	always_comb begin
		state_next = state;
		case (state)
			icebreaker_pkg::TEST_LOGIC_RESET:
				state_next = tms_s ? icebreaker_pkg::TEST_LOGIC_RESET : icebreaker_pkg::RUN_TEST_IDLE;
			icebreaker_pkg::RUN_TEST_IDLE:
				state_next = tms_s ? icebreaker_pkg::SELECT_DR : icebreaker_pkg::RUN_TEST_IDLE;
			icebreaker_pkg::SELECT_DR:
				state_next = tms_s ? icebreaker_pkg::SELECT_IR : icebreaker_pkg::CAPTURE_DR;
			icebreaker_pkg::CAPTURE_DR:
				state_next = tms_s ? icebreaker_pkg::EXIT1_DR : icebreaker_pkg::SHIFT_DR;
			icebreaker_pkg::SHIFT_DR:
				state_next = tms_s ? icebreaker_pkg::EXIT1_DR : icebreaker_pkg::SHIFT_DR;
			icebreaker_pkg::EXIT1_DR:
				state_next = tms_s ? icebreaker_pkg::UPDATE_DR : icebreaker_pkg::PAUSE_DR;
			icebreaker_pkg::PAUSE_DR:
				state_next = tms_s ? icebreaker_pkg::EXIT2_DR : icebreaker_pkg::PAUSE_DR;
			icebreaker_pkg::EXIT2_DR:
				state_next = tms_s ? icebreaker_pkg::UPDATE_DR : icebreaker_pkg::SHIFT_DR;
			icebreaker_pkg::UPDATE_DR:
				state_next = tms_s ? icebreaker_pkg::SELECT_DR : icebreaker_pkg::RUN_TEST_IDLE;
			icebreaker_pkg::SELECT_IR:
				state_next = tms_s ? icebreaker_pkg::TEST_LOGIC_RESET : icebreaker_pkg::CAPTURE_IR;
			icebreaker_pkg::CAPTURE_IR:
				state_next = tms_s ? icebreaker_pkg::EXIT1_IR : icebreaker_pkg::SHIFT_IR;
			icebreaker_pkg::SHIFT_IR:
				state_next = tms_s ? icebreaker_pkg::EXIT1_IR : icebreaker_pkg::SHIFT_IR;
			icebreaker_pkg::EXIT1_IR:
				state_next = tms_s ? icebreaker_pkg::UPDATE_IR : icebreaker_pkg::PAUSE_IR;
			icebreaker_pkg::PAUSE_IR:
				state_next = tms_s ? icebreaker_pkg::EXIT2_IR : icebreaker_pkg::PAUSE_IR;
			icebreaker_pkg::EXIT2_IR:
				state_next = tms_s ? icebreaker_pkg::UPDATE_IR : icebreaker_pkg::SHIFT_IR;
			default: // Update-IR
				state_next = tms_s ? icebreaker_pkg::SELECT_DR : icebreaker_pkg::RUN_TEST_IDLE;
		endcase
	end

	// tdi enters at the top of whichever register the IR selects
	always_comb begin
		dr_shifted = dr >> 1;
		case (ir)
			icebreaker_pkg::IR_IDCODE:  dr_shifted[31] = tdi_s;
			icebreaker_pkg::IR_MAILBOX: dr_shifted[icebreaker_pkg::MBOX_DR_W-1] = tdi_s;
			default:                    dr_shifted[0] = tdi_s; // Bypass, 1 bit
		endcase
	end

	// Shift datapath
	always_ff @(posedge clk) begin
		if (tck_rise) begin
			case (state)
				icebreaker_pkg::CAPTURE_DR: begin
					case (ir)
						icebreaker_pkg::IR_IDCODE:  dr <= icebreaker_pkg::IDCODE_VALUE;
						icebreaker_pkg::IR_MAILBOX: dr <= 32'(stat);
						default:                    dr <= '0;
					endcase
				end
				icebreaker_pkg::SHIFT_DR:   dr <= dr_shifted;
				icebreaker_pkg::CAPTURE_IR: ir_sh <= 4'b0001; // Fixed 01 tail per the standard
				icebreaker_pkg::SHIFT_IR:   ir_sh <= {tdi_s, ir_sh[3:1]};
				default: ;
			endcase
		end
	end

	// Controller state, IR, tdo and command strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= icebreaker_pkg::TEST_LOGIC_RESET;
			ir    <= icebreaker_pkg::IR_IDCODE;
			tdo   <= 1'b0;
			cmd   <= '0;
		end else begin
			cmd <= '0; // Single-cycle strobe
			if (tck_rise) begin
				state <= state_next;
				if (state == icebreaker_pkg::TEST_LOGIC_RESET)
					ir <= icebreaker_pkg::IR_IDCODE;
				else if (state_next == icebreaker_pkg::UPDATE_IR)
					ir <= ir_sh;
				// DR is stable in Exit1/Exit2, so take it on entry to Update-DR
				if (state_next == icebreaker_pkg::UPDATE_DR && ir == icebreaker_pkg::IR_MAILBOX) begin
					{cmd.tx_go, cmd.rx_pop, cmd.clr_ovf, cmd.data} <=
						dr[icebreaker_pkg::MBOX_DR_W-1:0];
					cmd.valid <= 1'b1;
				end
			end
			if (tck_fall) begin
				if (state == icebreaker_pkg::SHIFT_DR)
					tdo <= dr[0];
				else if (state == icebreaker_pkg::SHIFT_IR)
					tdo <= ir_sh[0];
				else
					tdo <= 1'b0;
			end
		end
	end

endmodule

/* hdl/uart_link.sv */
//**********************************************************
// 8N1 UART, fixed divider
// Transmitter with start, data and stop framing
// Receiver with input synchroniser, mid-bit sampling
// and stop bit check
//**********************************************************

module uart_link #(
	parameter int CLK_DIV = 104 // clk cycles per bit
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tx_start,
	input  icebreaker_pkg::byte_t tx_data,
	output logic                  tx_busy,
	output logic                  uart_tx,
	input  logic                  uart_rx,
	output logic                  rx_valid,
	output icebreaker_pkg::byte_t rx_data
);

	localparam int DIV_W = $clog2(CLK_DIV);

	typedef logic [DIV_W-1:0] div_t; // Position inside one bit
	typedef logic [3:0]       bit_t; // Frame bit index, 0 is start

	div_t       tx_div;
	bit_t       tx_bit;
	logic [9:0] tx_sh;   // {stop, data, start}

	logic [1:0] rx_sync;
	logic       rx_line;
	logic       rx_busy;
	div_t       rx_div;
	bit_t       rx_bit;
	div_t       rx_target;
	icebreaker_pkg::byte_t rx_sh;

	// Transmitter
	always_ff @(posedge clk) begin
		if (rst) begin
			tx_busy <= 1'b0;
			tx_div  <= '0;
			tx_bit  <= '0;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_busy <= 1'b1;
				tx_div  <= '0;
				tx_bit  <= '0;
			end
		end else if (tx_div == div_t'(CLK_DIV - 1)) begin
			tx_div <= '0;
			if (tx_bit == bit_t'(9))
				tx_busy <= 1'b0; // Full stop bit done
			else
				tx_bit <= tx_bit + 1'b1;
		end else begin
			tx_div <= tx_div + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!tx_busy && tx_start)
			tx_sh <= {1'b1, tx_data, 1'b0};
		else if (tx_busy && tx_div == div_t'(CLK_DIV - 1))
			tx_sh <= {1'b1, tx_sh[9:1]}; // LSB first
	end

	assign uart_tx = tx_busy ? tx_sh[0] : 1'b1; // Line idles high

	// Receiver
	assign rx_line   = rx_sync[1];
	assign rx_target = (rx_bit == '0) ? div_t'(CLK_DIV / 2 - 1) : div_t'(CLK_DIV - 1);

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_sync  <= 2'b11;
			rx_busy  <= 1'b0;
			rx_div   <= '0;
			rx_bit   <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync  <= {rx_sync[0], uart_rx};
			rx_valid <= 1'b0;
			if (!rx_busy) begin
				if (!rx_line) begin // Start edge
					rx_busy <= 1'b1;
					rx_div  <= '0;
					rx_bit  <= '0;
				end
			end else if (rx_div == rx_target) begin
				rx_div <= '0;
				rx_bit <= rx_bit + 1'b1;
				if (rx_bit == '0 && rx_line)
					rx_busy <= 1'b0; // Glitch, not a start bit
				else if (rx_bit == bit_t'(9)) begin
					rx_busy  <= 1'b0;
					rx_valid <= rx_line; // Framing error drops the byte
				end
			end else begin
				rx_div <= rx_div + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_busy && rx_div == rx_target && rx_bit != '0 && rx_bit != bit_t'(9))
			rx_sh <= {rx_line, rx_sh[7:1]};
	end

	assign rx_data = rx_sh;

	// Mailbox must hold off while a frame is out
	a_no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
		!(tx_start && tx_busy));

endmodule

/* hdl/debug_mailbox.sv */
//**********************************************************
// Debug mailbox between the TAP and the UART
// Registered transmit request, receive FIFO,
// sticky overflow flag and the captured status word
//**********************************************************

module debug_mailbox #(
	parameter int RX_DEPTH = 4 // Power of two
) (
	input  logic                      clk,
	input  logic                      rst,
	input  icebreaker_pkg::mbox_cmd_t  cmd,
	output icebreaker_pkg::mbox_stat_t stat,
	output logic                      tx_start,
	output icebreaker_pkg::byte_t     tx_data,
	input  logic                      tx_busy,
	input  logic                      rx_valid,
	input  icebreaker_pkg::byte_t     rx_data
);

	localparam int PTR_W = $clog2(RX_DEPTH);
	localparam int CNT_W = $clog2(RX_DEPTH + 1);

	icebreaker_pkg::byte_t mem [RX_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             empty;
	logic             push;
	logic             pop;
	logic             overflow;

	assign full  = (count == CNT_W'(RX_DEPTH));
	assign empty = (count == '0);
	assign push  = rx_valid && !full;
	assign pop   = cmd.valid && cmd.rx_pop && !empty; // Pop on empty is ignored

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_start <= 1'b0;
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			tx_start <= cmd.valid && cmd.tx_go && !tx_busy; // Busy UART drops the byte
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(pop);
			if (rx_valid && full)
				overflow <= 1'b1; // Set wins over clear
			else if (cmd.valid && cmd.clr_ovf)
				overflow <= 1'b0;
		end
	end

	// Transmit byte and FIFO storage
	always_ff @(posedge clk) begin
		if (cmd.valid && cmd.tx_go)
			tx_data <= cmd.data;
		if (push)
			mem[wr_ptr] <= rx_data;
	end

	assign stat.overflow = overflow;
	assign stat.tx_busy  = tx_busy;
	assign stat.rx_valid = !empty;
	assign stat.rx_data  = mem[rd_ptr];

	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		count <= CNT_W'(RX_DEPTH));
	// A pop on empty would leave the read pointer ahead of the write pointer
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
		empty |-> rd_ptr == wr_ptr);

endmodule

/* hdl/fpga_icebreaker.sv */
//**********************************************************
// iCEBreaker board top
// JTAG pin mirrors for a logic analyser, reset stretcher,
// TAP, UART and the mailbox joining them
//**********************************************************

module fpga_icebreaker #(
	parameter int RST_SHIFT = 3,
	parameter int CLK_DIV   = 104, // 12 MHz oscillator, 115200 baud
	parameter int RX_DEPTH  = 4
) (
	input  logic clk_osc,
	input  logic rst,

	input  logic tck, // At most clk_osc / 8
	input  logic tms,
	input  logic tdi,
	output logic tdo,

	output logic mirror_tck,
	output logic mirror_tms,
	output logic mirror_tdi,
	output logic mirror_tdo,

	output logic uart_tx,
	input  logic uart_rx
);

	logic sys_rst;
	logic tx_start;
	logic tx_busy;
	logic rx_valid;
	icebreaker_pkg::byte_t      tx_data;
	icebreaker_pkg::byte_t      rx_data;
	icebreaker_pkg::mbox_cmd_t  mbox_cmd;
	icebreaker_pkg::mbox_stat_t mbox_stat;

	// Probe header copies
	assign mirror_tck = tck;
	assign mirror_tms = tms;
	assign mirror_tdi = tdi;
	assign mirror_tdo = tdo;

	fpga_reset #(.RST_SHIFT(RST_SHIFT)) fpga_reset_inst (
		.clk     (clk_osc),
		.rst     (rst),
		.rst_out (sys_rst)
	);

	jtag_tap jtag_tap_inst (
		.clk  (clk_osc),
		.rst  (sys_rst),
		.tck  (tck),
		.tms  (tms),
		.tdi  (tdi),
		.tdo  (tdo),
		.stat (mbox_stat),
		.cmd  (mbox_cmd)
	);

	debug_mailbox #(.RX_DEPTH(RX_DEPTH)) debug_mailbox_inst (
		.clk      (clk_osc),
		.rst      (sys_rst),
		.cmd      (mbox_cmd),
		.stat     (mbox_stat),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_busy  (tx_busy),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

	uart_link #(.CLK_DIV(CLK_DIV)) uart_link_inst (
		.clk      (clk_osc),
		.rst      (sys_rst),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_busy  (tx_busy),
		.uart_tx  (uart_tx),
		.uart_rx  (uart_rx),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

endmodule

/* tests/tb_fpga_icebreaker.sv */
//**********************************************************
// Directed testbench for the iCEBreaker board top
// JTAG bit driver with TAP reset, IR and DR scans
// UART frame driver and uart_tx frame decoder
// Galois LFSR for stimulus bytes
// IDCODE, bypass, transmit, receive FIFO, overflow, framing
//**********************************************************

module tb_fpga_icebreaker;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_DIV  = 16;
	localparam int TCK_HALF = 8;    // clk cycles per tck phase
	localparam int TX_WAIT  = 2000; // Start bit search limit in clk cycles
	localparam int POLL_MAX = 20;   // Status scans before giving up

	logic clk = 1'b0;
	logic rst;
	logic tck;
	logic tms;
	logic tdi;
	logic tdo;
	logic mirror_tck;
	logic mirror_tms;
	logic mirror_tdi;
	logic mirror_tdo;
	logic uart_tx;
	logic uart_rx;

	logic [15:0] lfsr_state = 16'd18971;
	int          errors       = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;

	fpga_icebreaker #(
		.RST_SHIFT (3),
		.CLK_DIV   (CLK_DIV),
		.RX_DEPTH  (4)
	) fpga_icebreaker_inst (
		.clk_osc    (clk),
		.rst        (rst),
		.tck        (tck),
		.tms        (tms),
		.tdi        (tdi),
		.tdo        (tdo),
		.mirror_tck (mirror_tck),
		.mirror_tms (mirror_tms),
		.mirror_tdi (mirror_tdi),
		.mirror_tdo (mirror_tdo),
		.uart_tx    (uart_tx),
		.uart_rx    (uart_rx)
	);

	always #4 clk = ~clk; // 8 ns period

	// Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// One step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r[i] = lfsr_state[0];
		end
		return r;
	endfunction

	task automatic report_mismatch(input string test, input logic [31:0] exp,
			input logic [31:0] act);
		$display("Mismatch in %s: expected %0h, actual %0h", test, exp, act);
		errors++;
	endtask

	task automatic close_test(input string test, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("%s: passed", test);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", test, errors - start_errors);
		end
	endtask

	// One tck period with tdo read just before the rise
	task automatic jtag_clock(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(posedge clk);
		tck <= 1'b0;
		tms <= tms_v;
		tdi <= tdi_v;
		repeat (TCK_HALF - 1) @(posedge clk);
		@(negedge clk);
		tdo_v = tdo;
		if (mirror_tdo !== tdo) begin // Probe copy must track live scan data
			$display("mirror_tdo does not follow tdo during a scan");
			errors++;
		end
		@(posedge clk);
		tck <= 1'b1;
		repeat (TCK_HALF - 1) @(posedge clk);
	endtask

	// Five tms ones reach Test-Logic-Reset from anywhere, then park in Run-Test/Idle
	task automatic tap_reset();
		logic unused;
		for (int i = 0; i < 5; i++)
			jtag_clock(1'b1, 1'b0, unused);
		jtag_clock(1'b0, 1'b0, unused);
	endtask

	task automatic shift_ir(input icebreaker_pkg::ir_t code);
		logic unused;
		jtag_clock(1'b1, 1'b0, unused); // Select-DR
		jtag_clock(1'b1, 1'b0, unused); // Select-IR
		jtag_clock(1'b0, 1'b0, unused); // Capture-IR
		jtag_clock(1'b0, 1'b0, unused); // Shift-IR
		for (int i = 0; i < 4; i++)
			jtag_clock(i == 3, code[i], unused); // LSB first, last bit exits
		jtag_clock(1'b1, 1'b0, unused); // Update-IR
		jtag_clock(1'b0, 1'b0, unused); // Back to idle
	endtask

	task automatic shift_dr(input logic [31:0] din, input int len, output logic [31:0] dout);
		logic bit_v;
		dout = '0;
		jtag_clock(1'b1, 1'b0, bit_v); // Select-DR
		jtag_clock(1'b0, 1'b0, bit_v); // Capture-DR
		jtag_clock(1'b0, 1'b0, bit_v); // Shift-DR
		for (int i = 0; i < len; i++) begin
			jtag_clock(i == len - 1, din[i], bit_v);
			dout[i] = bit_v;
		end
		jtag_clock(1'b1, 1'b0, bit_v); // Update-DR
		jtag_clock(1'b0, 1'b0, bit_v);
	endtask

	// Status comes back from the same scan that carries the command
	task automatic mbox_access(input logic tx_go, input logic rx_pop, input logic clr_ovf,
			input icebreaker_pkg::byte_t data, output icebreaker_pkg::mbox_stat_t stat);
		logic [31:0] dout;
		shift_dr({21'b0, tx_go, rx_pop, clr_ovf, data}, icebreaker_pkg::MBOX_DR_W, dout);
		stat = dout[10:0];
	endtask

	task automatic uart_send_frame(input icebreaker_pkg::byte_t b, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, b, 1'b0};
		for (int k = 0; k < 10; k++) begin
			@(posedge clk);
			uart_rx <= frame[k]; // LSB first after the start bit
			repeat (CLK_DIV - 1) @(posedge clk);
		end
		@(posedge clk);
		uart_rx <= 1'b1;
		repeat (2 * CLK_DIV) @(posedge clk); // Idle gap
	endtask

	// Decodes one uart_tx frame at mid-bit
	task automatic uart_receive_frame(output icebreaker_pkg::byte_t b, output logic ok);
		int   waited;
		logic start_low;
		waited = 0;
		b      = '0;
		ok     = 1'b0;
		while (uart_tx !== 1'b0 && waited < TX_WAIT) begin
			@(negedge clk);
			waited++;
		end
		if (uart_tx !== 1'b0) begin
			$display("Timeout: no start bit seen on uart_tx");
			errors++;
			return;
		end
		repeat (CLK_DIV / 2) @(negedge clk);
		start_low = (uart_tx === 1'b0);
		for (int i = 0; i < 8; i++) begin
			repeat (CLK_DIV) @(negedge clk);
			b[i] = uart_tx;
		end
		repeat (CLK_DIV) @(negedge clk);
		ok = start_low && (uart_tx === 1'b1);
	endtask

	// Polls status until tx_busy clears, noting whether it was seen high
	task automatic wait_tx_idle(output logic seen_busy);
		icebreaker_pkg::mbox_stat_t st;
		int polls;
		seen_busy = 1'b0;
		polls     = 0;
		st.tx_busy = 1'b1;
		while (st.tx_busy && polls < POLL_MAX) begin
			mbox_access(1'b0, 1'b0, 1'b0, 8'h00, st);
			seen_busy = seen_busy | st.tx_busy;
			polls++;
		end
		if (st.tx_busy) begin
			$display("Timeout: tx_busy never cleared in the mailbox status");
			errors++;
		end
	endtask

	task automatic test_idcode_and_mirrors();
		string       name = "idcode_mirrors";
		int          start_errors = errors;
		logic [31:0] dout;
		if (tdo !== 1'b0)
			report_mismatch(name, 32'h0, tdo);
		if (uart_tx !== 1'b1)
			report_mismatch(name, 32'h1, uart_tx);
		tap_reset();
		shift_dr(32'h0, 32, dout); // IR still holds IDCODE from reset
		if (dout !== icebreaker_pkg::IDCODE_VALUE)
			report_mismatch(name, icebreaker_pkg::IDCODE_VALUE, dout);
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			tck <= i[2]; // Only one rise, with tms low, so the TAP stays idle
			tms <= i[1];
			tdi <= i[0];
			@(negedge clk);
			if ({mirror_tck, mirror_tms, mirror_tdi, mirror_tdo} !== {tck, tms, tdi, tdo})
				report_mismatch(name, {tck, tms, tdi, tdo},
					{mirror_tck, mirror_tms, mirror_tdi, mirror_tdo});
		end
		tap_reset();
		close_test(name, start_errors);
	endtask

	task automatic test_bypass();
		string       name = "bypass";
		int          start_errors = errors;
		logic [15:0] pattern;
		logic [31:0] dout;
		pattern = 16'(random_bits(16));
		shift_ir(icebreaker_pkg::IR_BYPASS);
		shift_dr({16'h0, pattern}, 17, dout);
		if (dout[16:0] !== {pattern, 1'b0}) // One tck late, captured 0 first
			report_mismatch(name, {pattern, 1'b0}, dout[16:0]);
		close_test(name, start_errors);
	endtask

	task automatic test_uart_transmit();
		string                      name = "uart_transmit";
		int                         start_errors = errors;
		icebreaker_pkg::byte_t      b;
		icebreaker_pkg::byte_t      got;
		icebreaker_pkg::mbox_stat_t st;
		logic                       ok;
		logic                       seen_busy;
		shift_ir(icebreaker_pkg::IR_MAILBOX);
		for (int n = 0; n < 2; n++) begin
			b = icebreaker_pkg::byte_t'(random_bits(8));
			fork
				begin
					mbox_access(1'b1, 1'b0, 1'b0, b, st);
					wait_tx_idle(seen_busy);
				end
				uart_receive_frame(got, ok);
			join
			if (st.tx_busy !== 1'b0) // UART idle when the send command went in
				report_mismatch(name, 32'h0, st.tx_busy);
			if (!ok) begin
				$display("%s: frame on uart_tx had a bad start or stop bit", name);
				errors++;
			end
			if (got !== b)
				report_mismatch(name, b, got);
			if (seen_busy !== 1'b1) begin
				$display("%s: tx_busy was never seen high while sending", name);
				errors++;
			end
		end
		close_test(name, start_errors);
	endtask

	task automatic test_uart_receive();
		string                      name = "uart_receive";
		int                         start_errors = errors;
		icebreaker_pkg::byte_t      sent[$];
		icebreaker_pkg::mbox_stat_t st;
		shift_ir(icebreaker_pkg::IR_MAILBOX);
		for (int n = 0; n < 3; n++) begin
			sent.push_back(icebreaker_pkg::byte_t'(random_bits(8)));
			uart_send_frame(sent[n], 1'b1);
		end
		foreach (sent[n]) begin
			mbox_access(1'b0, 1'b1, 1'b0, 8'h00, st); // Head captured, then popped
			if (st.rx_valid !== 1'b1)
				report_mismatch(name, 32'h1, st.rx_valid);
			if (st.rx_data !== sent[n])
				report_mismatch(name, sent[n], st.rx_data);
		end
		mbox_access(1'b0, 1'b0, 1'b0, 8'h00, st);
		if (st.rx_valid !== 1'b0)
			report_mismatch(name, 32'h0, st.rx_valid);
		if (st.overflow !== 1'b0)
			report_mismatch(name, 32'h0, st.overflow);
		close_test(name, start_errors);
	endtask

	task automatic test_overflow();
		string                      name = "overflow";
		int                         start_errors = errors;
		icebreaker_pkg::byte_t      sent[$];
		icebreaker_pkg::mbox_stat_t st;
		shift_ir(icebreaker_pkg::IR_MAILBOX);
		for (int n = 0; n < 5; n++) begin
			sent.push_back(icebreaker_pkg::byte_t'(random_bits(8)));
			uart_send_frame(sent[n], 1'b1);
		end
		for (int n = 0; n < 4; n++) begin // Fifth byte was lost
			mbox_access(1'b0, 1'b1, 1'b0, 8'h00, st);
			if (st.rx_data !== sent[n])
				report_mismatch(name, sent[n], st.rx_data);
			if (st.overflow !== 1'b1)
				report_mismatch(name, 32'h1, st.overflow);
		end
		mbox_access(1'b0, 1'b0, 1'b0, 8'h00, st);
		if (st.rx_valid !== 1'b0)
			report_mismatch(name, 32'h0, st.rx_valid);
		mbox_access(1'b0, 1'b0, 1'b1, 8'h00, st); // Clear overflow
		mbox_access(1'b0, 1'b0, 1'b0, 8'h00, st);
		if (st.overflow !== 1'b0)
			report_mismatch(name, 32'h0, st.overflow);
		close_test(name, start_errors);
	endtask

	task automatic test_bad_stop_bit();
		string                      name = "bad_stop_bit";
		int                         start_errors = errors;
		icebreaker_pkg::mbox_stat_t st;
		shift_ir(icebreaker_pkg::IR_MAILBOX);
		uart_send_frame(icebreaker_pkg::byte_t'(random_bits(8)), 1'b0);
		mbox_access(1'b0, 1'b0, 1'b0, 8'h00, st);
		if (st.rx_valid !== 1'b0)
			report_mismatch(name, 32'h0, st.rx_valid);
		close_test(name, start_errors);
	endtask

	initial begin
		rst     = 1'b1;
		tck     = 1'b0;
		tms     = 1'b1;
		tdi     = 1'b0;
		uart_rx = 1'b1; // Idle line
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		repeat (8) @(posedge clk); // Stretcher releases after 3 cycles
		test_idcode_and_mirrors();
		test_bypass();
		test_uart_transmit();
		test_uart_receive();
		test_overflow();
		test_bad_stop_bit();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* fpga_icebreaker.f */
hdl/icebreaker_pkg.sv
hdl/fpga_reset.sv
hdl/jtag_tap.sv
hdl/uart_link.sv
hdl/debug_mailbox.sv
hdl/fpga_icebreaker.sv
tests/tb_fpga_icebreaker.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_fpga_icebreaker \
	-f fpga_icebreaker.f -Mdir obj_dir -o tb_fpga_icebreaker
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_fpga_icebreaker > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "No result line in sim.log"
	exit 1
fi
exit 0
